//--- rtl/cpu_pkg.sv
// shared types for the rv32i subset core
// only word transfers exist, so a bus request carries no byte select
// immediates leave the decoder already sign extended
package cpu_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        // lui result is the immediate itself
        ALU_PASS_IMM
    } alu_op_e;

    // decoded control for one instruction
    typedef struct packed {
        alu_op_e    alu_op;
        // branch condition, raw funct3
        logic [2:0] funct3;
        logic       use_imm;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jal;
        logic       writes_rd;
        logic       illegal;
        reg_idx_t   rd;
    } dec_ctrl_t;

    // one word transfer toward the bus manager
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/100ps
// purely combinational decode of the instruction register
// unsupported encodings come out as illegal with every action flag cleared,
// so they retire as a no-op
module instr_decoder import cpu_pkg::*; (
    input  word_t     instr_i,
    output dec_ctrl_t ctrl_o,
    output reg_idx_t  rs1_o,
    output reg_idx_t  rs2_o,
    output word_t     imm_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    f3_op;
    logic       f3_ok;
    logic       legal;
    word_t      imm_i_w, imm_s_w, imm_b_w, imm_u_w, imm_j_w;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    // immediate formats
    assign imm_i_w = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_w = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_w = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
    assign imm_u_w = {instr_i[31:12], 12'b0};
    assign imm_j_w = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};

    // funct3 map shared by register and immediate forms
    always_comb begin
        f3_op = ALU_ADD;
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.funct3 = funct3;
        ctrl_o.rd     = instr_i[11:7];
        imm_o         = imm_i_w;
        legal         = 1'b1;
        case (opcode)
            OP: begin
                ctrl_o.writes_rd = 1'b1;
                ctrl_o.alu_op    = f3_op;
                // sub is the only funct7 variant kept
                if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    ctrl_o.alu_op = ALU_SUB;
                end else begin
                    legal = f3_ok && (funct7 == 7'b0);
                end
            end
            OP_IMM: begin
                ctrl_o.writes_rd = 1'b1;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.alu_op    = f3_op;
                // shifts need a clean funct7, srai is not supported
                legal = f3_ok && (funct3[1:0] != 2'b01 || funct7 == 7'b0);
            end
            LOAD: begin
                ctrl_o.writes_rd = 1'b1;
                ctrl_o.is_load   = 1'b1;
                legal = (funct3 == 3'b010);
            end
            STORE: begin
                ctrl_o.is_store = 1'b1;
                imm_o = imm_s_w;
                legal = (funct3 == 3'b010);
            end
            BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                imm_o = imm_b_w;
                legal = (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101});
            end
            JAL: begin
                ctrl_o.writes_rd = 1'b1;
                ctrl_o.is_jal    = 1'b1;
                imm_o = imm_j_w;
            end
            LUI: begin
                ctrl_o.writes_rd = 1'b1;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.alu_op    = ALU_PASS_IMM;
                imm_o = imm_u_w;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl_o         = '0;
            ctrl_o.illegal = 1'b1;
        end
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/100ps
// 32 x 32 register file, reads are combinational
// x0 is hardwired to zero by dropping writes to it
module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t wr_idx_i,
    input  logic     wr_en_i,
    input  word_t    wr_data_i,
    output word_t    rs1_val_o,
    output word_t    rs2_val_o
);

    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_idx_i != 5'd0) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // read ports
    assign rs1_val_o = regs[rs1_i];
    assign rs2_val_o = regs[rs2_i];

endmodule

//--- rtl/alu_branch.sv
`timescale 1ns/100ps
// combinational datapath for one instruction
// branch compares are unsigned, so blt and bge behave like bltu and bgeu
// take_branch_o is also raised for jal
module alu_branch import cpu_pkg::*; (
    input  dec_ctrl_t ctrl_i,
    input  word_t     rs1_val_i,
    input  word_t     rs2_val_i,
    input  word_t     imm_i,
    input  word_t     pc_i,
    output word_t     result_o,
    output word_t     mem_addr_o,
    output logic      take_branch_o
);

    word_t op_b;
    logic  cond;

    assign op_b = ctrl_i.use_imm ? imm_i : rs2_val_i;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:      result_o = rs1_val_i + op_b;
            ALU_SUB:      result_o = rs1_val_i - op_b;
            ALU_XOR:      result_o = rs1_val_i ^ op_b;
            ALU_OR:       result_o = rs1_val_i | op_b;
            ALU_AND:      result_o = rs1_val_i & op_b;
            ALU_SLL:      result_o = rs1_val_i << op_b[4:0];
            ALU_SRL:      result_o = rs1_val_i >> op_b[4:0];
            ALU_PASS_IMM: result_o = imm_i;
            default:      result_o = rs1_val_i + op_b;
        endcase
        // link address
        if (ctrl_i.is_jal) begin
            result_o = pc_i + 32'd4;
        end
    end

    // lw and sw address
    assign mem_addr_o = rs1_val_i + imm_i;

    always_comb begin
        case (ctrl_i.funct3)
            3'b000:  cond = (rs1_val_i == rs2_val_i);
            3'b001:  cond = (rs1_val_i != rs2_val_i);
            3'b100:  cond = (rs1_val_i < rs2_val_i);
            3'b101:  cond = (rs1_val_i >= rs2_val_i);
            default: cond = 1'b0;
        endcase
    end

    assign take_branch_o = (ctrl_i.is_branch && cond) || ctrl_i.is_jal;

endmodule

//--- rtl/core_sequencer.sv
`timescale 1ns/100ps
// multicycle control: IDLE, FETCH, EXECUTE, optional MEM, WRITEBACK
// en_i is sampled in IDLE only, an instruction in flight always retires
// one request per bus wait state, held until rsp_done_i
module core_sequencer import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h3300_0000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      en_i,
    input  dec_ctrl_t ctrl_i,
    input  word_t     imm_i,
    input  word_t     alu_result_i,
    input  word_t     mem_addr_i,
    input  word_t     rs2_val_i,
    input  logic      take_branch_i,
    input  logic      busy_i,
    input  logic      rsp_done_i,
    input  word_t     rsp_data_i,
    output word_t     instr_o,
    output word_t     pc_o,
    output logic      req_valid_o,
    output bus_req_t  req_o,
    output logic      wr_en_o,
    output reg_idx_t  wr_idx_o,
    output word_t     wr_data_o
);

    typedef enum logic [2:0] {IDLE, FETCH, EXECUTE, MEM, WRITEBACK} seq_state_e;

    seq_state_e state;
    word_t      pc_q, ir_q, result_q, addr_q, store_q, load_q;
    logic       take_q;
    logic       issued_q;
    logic       waiting;
    logic       mem_access;

    assign waiting     = (state == FETCH) || (state == MEM);
    assign req_valid_o = waiting && !issued_q;
    assign mem_access  = (ctrl_i.is_load || ctrl_i.is_store) && !ctrl_i.illegal;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pc_q     <= RESET_PC;
            take_q   <= 1'b0;
            issued_q <= 1'b0;
        end else begin
            // request goes out once per wait state
            if (rsp_done_i) begin
                issued_q <= 1'b0;
            end else if (req_valid_o && !busy_i) begin
                issued_q <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (en_i) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (rsp_done_i) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    take_q <= take_branch_i;
                    state  <= mem_access ? MEM : WRITEBACK;
                end
                MEM: begin
                    if (rsp_done_i) begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    pc_q  <= take_q ? pc_q + imm_i : pc_q + 32'd4;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // instruction and execute results
    always_ff @(posedge clk) begin
        if (state == FETCH && rsp_done_i) begin
            ir_q <= rsp_data_i;
        end
        if (state == EXECUTE) begin
            result_q <= alu_result_i;
            addr_q   <= mem_addr_i;
            store_q  <= rs2_val_i;
        end
        if (state == MEM && rsp_done_i) begin
            load_q <= rsp_data_i;
        end
    end

    always_comb begin
        req_o.addr  = pc_q;
        req_o.wdata = '0;
        req_o.we    = 1'b0;
        if (state == MEM) begin
            req_o.addr  = addr_q;
            req_o.wdata = store_q;
            req_o.we    = ctrl_i.is_store;
        end
    end

    assign instr_o   = ir_q;
    assign pc_o      = pc_q;
    assign wr_en_o   = (state == WRITEBACK) && ctrl_i.writes_rd;
    assign wr_idx_o  = ctrl_i.rd;
    assign wr_data_o = ctrl_i.is_load ? load_q : result_q;

    // a request is neither withdrawn nor changed before its response
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        waiting && !rsp_done_i |=> waiting && $stable(req_o));

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, FETCH, EXECUTE, MEM, WRITEBACK});

endmodule

//--- rtl/wb_manager.sv
`timescale 1ns/100ps
// wishbone classic manager, one single transfer at a time
// stb and cyc rise the cycle after accept and drop the cycle after ack
// no retry or error handling, the slave must eventually ack
module wb_manager import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    input  word_t    wb_dat_i,
    input  logic     wb_ack_i,
    output logic     busy_o,
    output logic     rsp_done_o,
    output word_t    rsp_data_o,
    output word_t    wb_adr_o,
    output word_t    wb_dat_o,
    output logic     wb_we_o,
    output logic     wb_stb_o,
    output logic     wb_cyc_o
);

    typedef enum logic {W_IDLE, ACTIVE} wb_state_e;

    wb_state_e state;
    logic      accept;

    assign busy_o = (state == ACTIVE);
    assign accept = req_valid_i && !busy_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= W_IDLE;
            wb_adr_o   <= '0;
            wb_dat_o   <= '0;
            wb_we_o    <= 1'b0;
            wb_stb_o   <= 1'b0;
            wb_cyc_o   <= 1'b0;
            rsp_done_o <= 1'b0;
        end else begin
            rsp_done_o <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (accept) begin
                        wb_adr_o <= req_i.addr;
                        wb_dat_o <= req_i.wdata;
                        wb_we_o  <= req_i.we;
                        wb_stb_o <= 1'b1;
                        wb_cyc_o <= 1'b1;
                        state    <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (wb_ack_i) begin
                        wb_adr_o   <= '0;
                        wb_dat_o   <= '0;
                        wb_we_o    <= 1'b0;
                        wb_stb_o   <= 1'b0;
                        wb_cyc_o   <= 1'b0;
                        rsp_done_o <= 1'b1;
                        state      <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // read data sampled on the ack cycle
    always_ff @(posedge clk) begin
        if (state == ACTIVE && wb_ack_i) begin
            rsp_data_o <= wb_dat_i;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb_o |-> wb_cyc_o);

    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/100ps
// rv32i subset core with a wishbone classic manager port
// word accesses only, no byte select lines
// RESET_PC is the first fetch address
module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h3300_0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  en_i,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i,
    output word_t wb_adr_o,
    output word_t wb_dat_o,
    output logic  wb_we_o,
    output logic  wb_stb_o,
    output logic  wb_cyc_o
);

    dec_ctrl_t ctrl;
    reg_idx_t  rs1_idx, rs2_idx, wr_idx;
    word_t     instr, pc, imm, rs1_val, rs2_val;
    word_t     alu_result, mem_addr, wr_data, rsp_data;
    logic      take_branch, wr_en;
    logic      req_valid, busy, rsp_done;
    bus_req_t  req;

    core_sequencer #(
        .RESET_PC(RESET_PC)
    ) u_seq (
        .clk(clk), .rst(rst), .en_i(en_i),
        .ctrl_i(ctrl), .imm_i(imm), .alu_result_i(alu_result),
        .mem_addr_i(mem_addr), .rs2_val_i(rs2_val), .take_branch_i(take_branch),
        .busy_i(busy), .rsp_done_i(rsp_done), .rsp_data_i(rsp_data),
        .instr_o(instr), .pc_o(pc), .req_valid_o(req_valid), .req_o(req),
        .wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data)
    );

    // decoder and register file both look at the instruction register
    instr_decoder u_dec (
        .instr_i(instr), .ctrl_o(ctrl), .rs1_o(rs1_idx), .rs2_o(rs2_idx), .imm_o(imm)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .rs1_i(rs1_idx), .rs2_i(rs2_idx),
        .wr_idx_i(wr_idx), .wr_en_i(wr_en), .wr_data_i(wr_data),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

    alu_branch u_alu (
        .ctrl_i(ctrl), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val), .imm_i(imm),
        .pc_i(pc), .result_o(alu_result), .mem_addr_o(mem_addr),
        .take_branch_o(take_branch)
    );

    wb_manager u_wb (
        .clk(clk), .rst(rst), .req_valid_i(req_valid), .req_i(req),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .busy_o(busy), .rsp_done_o(rsp_done), .rsp_data_o(rsp_data),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_we_o(wb_we_o),
        .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
    );

endmodule

//--- testbench/tb_ref_model.svh
// instruction-set model of the supported subset, run on ref_mem
// branch compares are unsigned, illegal words retire as no-ops
// stops at the first jal with a zero offset, the program's self-loop
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic void run_ref(input word_t base);
    word_t      x [32];
    word_t      pc, ins, ii, is, ib, ij, a, b, r, addr;
    logic [6:0] op, f7;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    logic       ok;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc = base;
    for (int step = 0; step < 500; step++) begin
        ins = ref_mem[(pc - base) >> 2];
        exp_reads.push_back(pc);
        op  = ins[6:0];
        rd  = ins[11:7];
        f3  = ins[14:12];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        f7  = ins[31:25];
        ii  = {{20{ins[31]}}, ins[31:20]};
        is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ib  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        ij  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        a   = x[rs1];
        b   = (op == 7'h13) ? ii : x[rs2];
        ok  = 1'b1;
        r   = '0;
        case (f3)
            3'd0: r = (op == 7'h33 && f7 == 7'h20) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd4: r = a ^ b;
            3'd5: r = a >> b[4:0];
            3'd6: r = a | b;
            3'd7: r = a & b;
            default: ok = 1'b0;
        endcase
        addr = pc + 32'd4;
        case (op)
            7'h33: if (ok && (f7 == 7'h0 || (f3 == 3'd0 && f7 == 7'h20))) x[rd] = r;
            7'h13: if (ok && (f3[1:0] != 2'b01 || f7 == 7'h0)) x[rd] = r;
            7'h37: x[rd] = {ins[31:12], 12'h0};
            7'h03: if (f3 == 3'd2) begin
                exp_reads.push_back(a + ii);
                x[rd] = ref_mem[(a + ii - base) >> 2];
            end
            7'h23: if (f3 == 3'd2) begin
                exp_waddr.push_back(a + is);
                exp_wdata.push_back(x[rs2]);
                ref_mem[(a + is - base) >> 2] = x[rs2];
            end
            7'h63: begin
                if ((f3 == 3'd0 && a == x[rs2]) || (f3 == 3'd1 && a != x[rs2]) ||
                    (f3 == 3'd4 && a < x[rs2]) || (f3 == 3'd5 && a >= x[rs2])) begin
                    addr = pc + ib;
                end
            end
            7'h6f: begin
                if (ij == 32'd0) begin
                    return;
                end
                x[rd] = pc + 32'd4;
                addr  = pc + ij;
            end
            default: ;
        endcase
        x[0] = '0;
        pc   = addr;
    end
endfunction

`endif

//--- testbench/tb_cpu_top.sv
`timescale 1ns/100ps
// runs a fixed program from a word memory at RESET_PC with 0 to 3 ack wait states
// stores and bus reads are compared against the instruction-set model
module tb_cpu_top;
    import cpu_pkg::*;

    localparam word_t RESET_PC  = 32'h3300_0000;
    localparam int    MEM_WORDS = 128;
    localparam int    PROG_LEN  = 40;
    localparam word_t X0_ADDR   = RESET_PC + 32'h120;

    logic  clk = 1'b0;
    logic  rst, en_i, wb_ack_i, wb_we_o, wb_stb_o, wb_cyc_o;
    word_t wb_dat_i, wb_adr_o, wb_dat_o;
    word_t mem [MEM_WORDS];
    word_t ref_mem [MEM_WORDS];
    word_t exp_waddr [$];
    word_t exp_wdata [$];
    word_t exp_reads [$];
    integer seed = 9558;
    int    wait_left, idx, pause, failed;
    int    wr_count, rd_count;
    int    err_store, err_trace, err_x0, err_proto, err_en;
    logic  pending, prev_ack, prev_cyc, cyc_seen, x0_seen, hold_check;

    `include "tb_ref_model.svh"

    cpu_top #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .rst(rst), .en_i(en_i), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_we_o(wb_we_o),
        .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
    );

    always #5 clk = ~clk;

    function automatic word_t enc_i(input int imm, input int rs1, input int f3,
                                    input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input int imm, input int rs2, input int rs1,
                                    input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'h63};
    endfunction

    function automatic word_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic load_program();
        // data area filled with an address-derived pattern
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (RESET_PC + 32'(i * 4)) ^ 32'h5a5a_5a5a;
        end
        mem[0]  = {20'h33000, 5'd1, 7'h37};
        mem[1]  = enc_i(85, 0, 0, 2, 7'h13);
        mem[2]  = enc_i(-3, 0, 0, 3, 7'h13);
        mem[3]  = enc_r(0, 3, 2, 0, 4);
        mem[4]  = enc_r(32, 3, 2, 0, 5);
        mem[5]  = enc_s(256, 4, 1);
        mem[6]  = enc_s(260, 5, 1);
        mem[7]  = enc_r(0, 3, 2, 4, 6);
        mem[8]  = enc_r(0, 3, 2, 6, 7);
        mem[9]  = enc_r(0, 7, 6, 7, 8);
        mem[10] = enc_s(264, 8, 1);
        mem[11] = enc_i(4, 2, 1, 9, 7'h13);
        mem[12] = enc_i(28, 3, 5, 10, 7'h13);
        mem[13] = enc_r(0, 10, 2, 1, 11);
        mem[14] = enc_r(0, 2, 3, 5, 12);
        mem[15] = enc_s(268, 9, 1);
        mem[16] = enc_s(272, 11, 1);
        mem[17] = enc_s(276, 12, 1);
        mem[18] = enc_i(240, 3, 4, 13, 7'h13);
        mem[19] = enc_i(-256, 13, 6, 14, 7'h13);
        mem[20] = enc_i(2047, 14, 7, 15, 7'h13);
        mem[21] = enc_s(280, 15, 1);
        mem[22] = enc_i(256, 1, 2, 16, 7'h03);
        mem[23] = enc_i(1, 16, 0, 16, 7'h13);
        mem[24] = enc_s(284, 16, 1);
        // x0 must stay zero after a write attempt
        mem[25] = enc_i(5, 0, 0, 0, 7'h13);
        mem[26] = enc_s(288, 0, 1);
        mem[27] = enc_b(8, 3, 2, 0);
        mem[28] = enc_b(8, 3, 2, 1);
        mem[29] = enc_i(1, 0, 0, 17, 7'h13);
        mem[30] = 32'hffff_ffff;
        mem[31] = enc_b(8, 3, 2, 4);
        mem[32] = enc_i(2, 0, 0, 17, 7'h13);
        mem[33] = enc_b(8, 3, 2, 5);
        mem[34] = enc_i(7, 17, 0, 17, 7'h13);
        mem[35] = enc_j(8, 18);
        mem[36] = enc_i(9, 0, 0, 17, 7'h13);
        mem[37] = enc_s(292, 17, 1);
        mem[38] = enc_s(296, 18, 1);
        mem[39] = enc_j(0, 0);
    endtask

    // memory model and bus compare
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack_i <= 1'b0;
            pending  = 1'b0;
        end else begin
            wb_ack_i <= 1'b0;
            if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = $random(seed) & 3;
                end
                if (wait_left == 0) begin
                    pending  = 1'b0;
                    wb_ack_i <= 1'b1;
                    idx = int'((wb_adr_o - RESET_PC) >> 2);
                    assert (idx >= 0 && idx < MEM_WORDS) else begin
                        $display("access outside the memory model at %0t", $time);
                        err_proto++;
                        idx = 0;
                    end
                    if (wb_we_o) begin
                        mem[idx] = wb_dat_o;
                        assert (wr_count < exp_waddr.size() &&
                                wb_adr_o == exp_waddr[wr_count] &&
                                wb_dat_o == exp_wdata[wr_count]) else begin
                            $display("FAIL %0t: write %0d got %h <= %h", $time,
                                     wr_count, wb_adr_o, wb_dat_o);
                            err_store++;
                        end
                        if (wb_adr_o == X0_ADDR) begin
                            x0_seen = 1'b1;
                            assert (wb_dat_o == 32'd0) else begin
                                $display("FAIL %0t: x0 store wrote %h", $time, wb_dat_o);
                                err_x0++;
                            end
                        end
                        wr_count++;
                    end else begin
                        wb_dat_i <= mem[idx];
                        if (rd_count < exp_reads.size()) begin
                            assert (wb_adr_o == exp_reads[rd_count]) else begin
                                $display("FAIL %0t: read %0d at %h, expected %h", $time,
                                         rd_count, wb_adr_o, exp_reads[rd_count]);
                                err_trace++;
                            end
                        end
                        rd_count++;
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // protocol and enable monitor
    always @(posedge clk) begin
        assert (!(wb_stb_o && !wb_cyc_o)) else begin
            $display("FAIL %0t: STB high without CYC", $time);
            err_proto++;
        end
        assert (!(prev_ack && wb_stb_o)) else begin
            $display("FAIL %0t: STB still high after ACK", $time);
            err_proto++;
        end
        assert (!(rst && (wb_cyc_o || wb_stb_o))) else begin
            $display("FAIL %0t: bus active during reset", $time);
            err_proto++;
        end
        if (wb_cyc_o && !cyc_seen) begin
            cyc_seen = 1'b1;
            assert (wb_adr_o == RESET_PC && !wb_we_o) else begin
                $display("FAIL %0t: first cycle at %h", $time, wb_adr_o);
                err_proto++;
            end
        end
        assert (!(hold_check && wb_cyc_o && !prev_cyc)) else begin
            $display("FAIL %0t: bus cycle started with en_i low", $time);
            err_en++;
        end
        prev_ack = wb_ack_i;
        prev_cyc = wb_cyc_o;
    end

    // each instruction gets 60 cycles per wait state, plus reset and pause
    initial begin
        repeat (PROG_LEN * 60 * 4 + 300) @(posedge clk);
        $display("timeout: program did not finish, %0d writes and %0d reads seen",
                 wr_count, rd_count);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
            failed++;
        end
    endtask

    initial begin
        rst <= 1'b1;
        en_i <= 1'b0;
        wb_ack_i <= 1'b0;
        wb_dat_i <= '0;
        {wr_count, rd_count, failed} = '0;
        {err_store, err_trace, err_x0, err_proto, err_en} = '0;
        {pending, prev_ack, prev_cyc, cyc_seen, x0_seen, hold_check} = '0;
        load_program();
        ref_mem = mem;
        run_ref(RESET_PC);
        repeat (8) @(posedge clk);
        rst  <= 1'b0;
        en_i <= 1'b1;
        // pause after a few stores
        while (wr_count < 3) @(posedge clk);
        en_i <= 1'b0;
        // longest instruction is two transfers with three wait states each
        repeat (20) @(posedge clk);
        hold_check <= 1'b1;
        pause = 10 + ($random(seed) & 31);
        repeat (pause) @(posedge clk);
        hold_check <= 1'b0;
        en_i <= 1'b1;
        while (wr_count < exp_waddr.size() || rd_count < exp_reads.size()) @(posedge clk);
        repeat (30) @(posedge clk);
        assert (wr_count == exp_waddr.size()) else begin
            $display("extra bus writes after the program ended: %0d", wr_count);
            err_store++;
        end
        assert (x0_seen) else begin
            $display("the store of x0 never reached the bus");
            err_x0++;
        end
        report("store_sequence", err_store);
        report("read_trace", err_trace);
        report("x0_zero", err_x0);
        report("protocol", err_proto);
        report("enable_hold", err_en);
        $display("tests run 5, failed %0d", failed);
        if (failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+testbench
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu_branch.sv
rtl/core_sequencer.sv
rtl/wb_manager.sv
rtl/cpu_top.sv
testbench/tb_cpu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SRCS := $(wildcard rtl/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) flist.f
	$(VERILATOR) --binary --timing --assert -f flist.f --top-module $(TOP) \
		-Mdir $(BUILD) $(VFLAGS)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
